// ==== include/softmax_cfg.svh ====
// ====================
// Widths, depths and latencies of the softmax stage
// Included by the package and by every module that sizes from them
// ====================
`ifndef SOFTMAX_CFG_SVH
`define SOFTMAX_CFG_SVH

// Data widths
`define SM_COEF_WIDTH          4
`define SM_EXP_WIDTH           16
`define SM_NODE_CNT_WIDTH      5
`define SM_SUM_WIDTH           20
`define SM_ALPHA_WIDTH         16

// Subgraph table and queues
`define SM_NUM_SUBGRAPHS       8
`define SM_SUBGRAPH_ADDR_WIDTH 3
`define SM_FIFO_DEPTH          32

// Input register plus one stage per quotient bit
`define SM_DIV_LATENCY         (`SM_ALPHA_WIDTH + 1)

`endif

// ==== logic/softmax_pkg.sv ====
// ====================
// Shared data types and the divide-side state encoding
// ====================
`default_nettype none

`include "softmax_cfg.svh"

package softmax_pkg;

  // ====================
  // Data types
  // ====================
  typedef logic [`SM_COEF_WIDTH-1:0]          coef_t;
  typedef logic [`SM_EXP_WIDTH-1:0]           exp_t;
  typedef logic [`SM_SUM_WIDTH-1:0]           sum_t;
  typedef logic [`SM_NODE_CNT_WIDTH-1:0]      node_cnt_t;
  typedef logic [`SM_ALPHA_WIDTH-1:0]         alpha_t;
  typedef logic [`SM_SUBGRAPH_ADDR_WIDTH-1:0] subgraph_addr_t;

  // Divide side waits for a sum, then issues that subgraph's dividends
  typedef enum logic {
    DIV_IDLE,
    DIV_RUN
  } div_state_e;

endpackage

`default_nettype wire

// ==== logic/sync_fifo.sv ====
// ====================
// Synchronous FIFO, first-word fall-through
// dout shows the oldest entry whenever empty is low
// ====================
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
  parameter int DATA_WIDTH = 8,
  parameter int DEPTH      = 16
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  wr,
  input  logic [DATA_WIDTH-1:0] din,
  input  logic                  rd,
  output logic [DATA_WIDTH-1:0] dout,
  output logic                  empty,
  output logic                  full
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [DATA_WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0]      wr_ptr;
  logic [PTR_W-1:0]      rd_ptr;
  logic [CNT_W-1:0]      count;
  logic                  do_wr;
  logic                  do_rd;

  assign empty = (count == '0);
  assign full  = (count == CNT_W'(DEPTH));
  assign do_wr = wr && !full;
  assign do_rd = rd && !empty;
  assign dout  = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= din;
    end
  end

  // Pointers wrap at DEPTH, so any depth works
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== logic/node_count_ram.sv ====
// ====================
// Node count per subgraph, loaded before streaming
// One write port, registered read with one cycle latency
// ====================
`timescale 1ns/1ps
`default_nettype none

`include "softmax_cfg.svh"

module node_count_ram
  import softmax_pkg::*;
(
  input  logic           clk,
  input  logic           rst_n,
  input  logic           wr,
  input  subgraph_addr_t wr_addr,
  input  node_cnt_t      wr_data,
  input  subgraph_addr_t rd_addr,
  output node_cnt_t      rd_data
);

  node_cnt_t cnt_mem [`SM_NUM_SUBGRAPHS];

  always_ff @(posedge clk) begin
    if (wr) begin
      cnt_mem[wr_addr] <= wr_data;
    end
  end

  // Read register, old data on a same-address write
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_data <= '0;
    end else begin
      rd_data <= cnt_mem[rd_addr];
    end
  end

endmodule

`default_nettype wire

// ==== logic/fxp_div_pipe.sv ====
// ====================
// Pipelined restoring divider, one quotient bit per stage
// quotient = floor(dividend * 2^(QUOTIENT_WIDTH-1) / divisor), QUOTIENT_WIDTH+1 cycles
// ====================
`timescale 1ns/1ps
`default_nettype none

module fxp_div_pipe #(
  parameter int DIVIDEND_WIDTH = 16,
  parameter int DIVISOR_WIDTH  = 20,
  parameter int QUOTIENT_WIDTH = 16
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      in_vld,
  input  logic                      in_tag,
  input  logic [DIVIDEND_WIDTH-1:0] dividend,
  input  logic [DIVISOR_WIDTH-1:0]  divisor,
  output logic                      out_vld,
  output logic                      out_tag,
  output logic [QUOTIENT_WIDTH-1:0] quotient
);

  // One integer bit, the rest fraction
  localparam int FRAC_BITS = QUOTIENT_WIDTH - 1;
  localparam int WIDE_IN   = (DIVIDEND_WIDTH > DIVISOR_WIDTH) ? DIVIDEND_WIDTH : DIVISOR_WIDTH;
  localparam int REM_W     = WIDE_IN + QUOTIENT_WIDTH;

  // Index n holds the output of stage n, stage 0 is the input register
  logic [REM_W-1:0]          rem_q  [QUOTIENT_WIDTH];
  logic [DIVISOR_WIDTH-1:0]  dvsr_q [QUOTIENT_WIDTH];
  logic [QUOTIENT_WIDTH-1:0] quo_q  [1:QUOTIENT_WIDTH];
  logic [QUOTIENT_WIDTH:0]   vld_q;
  logic [QUOTIENT_WIDTH:0]   tag_q;

  // ====================
  // Valid and tag pipeline
  // ====================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld_q <= '0;
    end else begin
      vld_q <= {vld_q[QUOTIENT_WIDTH-1:0], in_vld};
    end
  end

  always_ff @(posedge clk) begin
    tag_q <= {tag_q[QUOTIENT_WIDTH-1:0], in_tag};
  end

  // Input register, dividend scaled by 2^FRAC_BITS
  always_ff @(posedge clk) begin
    rem_q[0]  <= {{(REM_W - DIVIDEND_WIDTH){1'b0}}, dividend} << FRAC_BITS;
    dvsr_q[0] <= divisor;
  end

  // ====================
  // Subtract stages, MSB of the quotient first
  // ====================
  for (genvar s = 1; s <= QUOTIENT_WIDTH; s++) begin : g_stage
    localparam int BIT = QUOTIENT_WIDTH - s;

    logic [REM_W-1:0] trial;
    logic             fits;

    assign trial = {{(REM_W - DIVISOR_WIDTH){1'b0}}, dvsr_q[s-1]} << BIT;
    assign fits  = (rem_q[s-1] >= trial);

    // First stage starts the quotient, later ones add their bit
    if (s == 1) begin : g_first
      always_ff @(posedge clk) begin
        quo_q[s] <= QUOTIENT_WIDTH'(fits) << BIT;
      end
    end else begin : g_next
      always_ff @(posedge clk) begin
        quo_q[s] <= quo_q[s-1] | (QUOTIENT_WIDTH'(fits) << BIT);
      end
    end

    // Last stage only needs the quotient
    if (s < QUOTIENT_WIDTH) begin : g_pass
      always_ff @(posedge clk) begin
        rem_q[s]  <= fits ? (rem_q[s-1] - trial) : rem_q[s-1];
        dvsr_q[s] <= dvsr_q[s-1];
      end
    end
  end

  assign out_vld  = vld_q[QUOTIENT_WIDTH];
  assign out_tag  = tag_q[QUOTIENT_WIDTH];
  assign quotient = quo_q[QUOTIENT_WIDTH];

endmodule

`default_nettype wire

// ==== logic/softmax.sv ====
// ====================
// Softmax core: 2^coef, per-subgraph sum, then 2^coef / sum in Q1.15
// Pops the coefficient FIFO and reads the node count table
// ====================
`timescale 1ns/1ps
`default_nettype none

`include "softmax_cfg.svh"

module softmax
  import softmax_pkg::*;
(
  input  logic           clk,
  input  logic           rst_n,
  input  coef_t          coef_ff_dout,
  input  logic           coef_ff_empty,
  input  node_cnt_t      num_node_dout,
  output logic           coef_ff_rd,
  output subgraph_addr_t num_node_addr,
  output logic           alpha_vld,
  output alpha_t         alpha,
  output logic           alpha_last
);

  localparam int DVSR_FF_WIDTH = `SM_NODE_CNT_WIDTH + `SM_SUM_WIDTH;

  // Input side
  subgraph_addr_t sg_idx;
  subgraph_addr_t sg_idx_nxt;
  node_cnt_t      node_cnt;
  sum_t           sum_acc;
  sum_t           sum_nxt;
  exp_t           exp_val;
  logic           last_node;

  // Queues
  logic                     divd_ff_rd;
  exp_t                     divd_ff_dout;
  logic                     divd_ff_empty;
  logic                     dvsr_ff_wr;
  logic [DVSR_FF_WIDTH-1:0] dvsr_ff_din;
  logic                     dvsr_ff_rd;
  logic [DVSR_FF_WIDTH-1:0] dvsr_ff_dout;
  logic                     dvsr_ff_empty;
  node_cnt_t                dvsr_num;
  sum_t                     dvsr_sum;

  // Divide side
  div_state_e div_state;
  node_cnt_t  div_num;
  node_cnt_t  div_cnt;
  sum_t       div_sum;
  logic       div_vld;
  logic       div_last;

  // ====================
  // Power of two and sum
  // ====================
  assign coef_ff_rd = !coef_ff_empty;
  assign exp_val    = exp_t'(1'b1) << coef_ff_dout;
  assign sum_nxt    = sum_acc + sum_t'(exp_val);
  assign last_node  = (node_cnt + 1'b1 == num_node_dout);

  always_comb begin
    sg_idx_nxt = sg_idx;
    if (coef_ff_rd && last_node) begin
      sg_idx_nxt = (sg_idx == subgraph_addr_t'(`SM_NUM_SUBGRAPHS - 1)) ? '0 : sg_idx + 1'b1;
    end
  end

  // Address leads by one edge so a new subgraph's count is ready on its first pop
  assign num_node_addr = sg_idx_nxt;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sg_idx   <= '0;
      node_cnt <= '0;
      sum_acc  <= '0;
    end else begin
      sg_idx <= sg_idx_nxt;
      if (coef_ff_rd) begin
        if (last_node) begin
          node_cnt <= '0;
          sum_acc  <= '0;
        end else begin
          node_cnt <= node_cnt + 1'b1;
          sum_acc  <= sum_nxt;
        end
      end
    end
  end

  // Sum goes out on the last node, together with the count
  assign dvsr_ff_wr  = coef_ff_rd && last_node;
  assign dvsr_ff_din = {num_node_dout, sum_nxt};

  sync_fifo #(
    .DATA_WIDTH (`SM_EXP_WIDTH),
    .DEPTH      (`SM_FIFO_DEPTH)
  ) i_divd_fifo (
    .clk   (clk),
    .rst_n (rst_n),
    .wr    (coef_ff_rd),
    .din   (exp_val),
    .rd    (divd_ff_rd),
    .dout  (divd_ff_dout),
    .empty (divd_ff_empty),
    .full  ()
  );

  sync_fifo #(
    .DATA_WIDTH (DVSR_FF_WIDTH),
    .DEPTH      (`SM_FIFO_DEPTH)
  ) i_dvsr_fifo (
    .clk   (clk),
    .rst_n (rst_n),
    .wr    (dvsr_ff_wr),
    .din   (dvsr_ff_din),
    .rd    (dvsr_ff_rd),
    .dout  (dvsr_ff_dout),
    .empty (dvsr_ff_empty),
    .full  ()
  );

  // ====================
  // Divide issue
  // ====================
  assign {dvsr_num, dvsr_sum} = dvsr_ff_dout;
  assign dvsr_ff_rd = (div_state == DIV_IDLE) && !dvsr_ff_empty;
  assign divd_ff_rd = (div_state == DIV_RUN) && !divd_ff_empty;
  assign div_vld    = divd_ff_rd;
  assign div_last   = (div_cnt + 1'b1 == div_num);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      div_state <= DIV_IDLE;
      div_cnt   <= '0;
    end else begin
      case (div_state)
        DIV_IDLE: begin
          if (dvsr_ff_rd) begin
            div_cnt   <= '0;
            div_state <= DIV_RUN;
          end
        end
        DIV_RUN: begin
          if (divd_ff_rd) begin
            if (div_last) begin
              div_state <= DIV_IDLE;
            end else begin
              div_cnt <= div_cnt + 1'b1;
            end
          end
        end
        default: div_state <= DIV_IDLE;
      endcase
    end
  end

  // Held for the whole subgraph
  always_ff @(posedge clk) begin
    if (dvsr_ff_rd) begin
      div_num <= dvsr_num;
      div_sum <= dvsr_sum;
    end
  end

  fxp_div_pipe #(
    .DIVIDEND_WIDTH (`SM_EXP_WIDTH),
    .DIVISOR_WIDTH  (`SM_SUM_WIDTH),
    .QUOTIENT_WIDTH (`SM_ALPHA_WIDTH)
  ) i_div (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_vld   (div_vld),
    .in_tag   (div_last),
    .dividend (divd_ff_dout),
    .divisor  (div_sum),
    .out_vld  (alpha_vld),
    .out_tag  (alpha_last),
    .quotient (alpha)
  );

endmodule

`default_nettype wire

// ==== logic/softmax_top.sv ====
// ====================
// Softmax stage top: coefficient FIFO, node count table and core
// ====================
`timescale 1ns/1ps
`default_nettype none

`include "softmax_cfg.svh"

module softmax_top
  import softmax_pkg::*;
(
  input  logic           clk,
  input  logic           rst_n,
  input  logic           cfg_wr,
  input  subgraph_addr_t cfg_addr,
  input  node_cnt_t      cfg_num_nodes,
  input  logic           coef_vld,
  input  coef_t          coef,
  output logic           alpha_vld,
  output alpha_t         alpha,
  output logic           alpha_last
);

  coef_t          coef_ff_dout;
  logic           coef_ff_empty;
  logic           coef_ff_rd;
  subgraph_addr_t num_node_addr;
  node_cnt_t      num_node_dout;

  sync_fifo #(
    .DATA_WIDTH (`SM_COEF_WIDTH),
    .DEPTH      (`SM_FIFO_DEPTH)
  ) i_coef_fifo (
    .clk   (clk),
    .rst_n (rst_n),
    .wr    (coef_vld),
    .din   (coef),
    .rd    (coef_ff_rd),
    .dout  (coef_ff_dout),
    .empty (coef_ff_empty),
    .full  ()
  );

  node_count_ram i_node_count_ram (
    .clk     (clk),
    .rst_n   (rst_n),
    .wr      (cfg_wr),
    .wr_addr (cfg_addr),
    .wr_data (cfg_num_nodes),
    .rd_addr (num_node_addr),
    .rd_data (num_node_dout)
  );

  softmax i_softmax (
    .clk           (clk),
    .rst_n         (rst_n),
    .coef_ff_dout  (coef_ff_dout),
    .coef_ff_empty (coef_ff_empty),
    .num_node_dout (num_node_dout),
    .coef_ff_rd    (coef_ff_rd),
    .num_node_addr (num_node_addr),
    .alpha_vld     (alpha_vld),
    .alpha         (alpha),
    .alpha_last    (alpha_last)
  );

endmodule

`default_nettype wire

// ==== testbench/tb_softmax_top.sv ====
// ====================
// Testbench for the softmax stage top level
// Loads the count table, streams coefficients from the pattern file, checks every weight
// ====================
`timescale 1ns/1ps
`default_nettype none

`include "softmax_cfg.svh"

module tb_softmax_top
  import softmax_pkg::*;
();

  localparam int MAX_COEF  = 64;
  localparam int NUM_SG    = `SM_NUM_SUBGRAPHS;
  localparam int PAT_WORDS = NUM_SG + 4 * (MAX_COEF + 1);

  logic           clk;
  logic           rst_n;
  logic           cfg_wr;
  subgraph_addr_t cfg_addr;
  node_cnt_t      cfg_num_nodes;
  logic           coef_vld;
  coef_t          coef;
  logic           alpha_vld;
  alpha_t         alpha;
  logic           alpha_last;

  // Pattern data, split into columns
  logic [15:0] pat_mem [PAT_WORDS];
  int          counts  [NUM_SG];
  coef_t       coef_a  [MAX_COEF];
  alpha_t      alpha_a [MAX_COEF];
  logic        last_a  [MAX_COEF];
  int          gap_a   [MAX_COEF];
  int          grp_a   [MAX_COEF];
  longint      grp_sum [MAX_COEF];
  int          grp_sg  [MAX_COEF];
  int          grp_n   [MAX_COEF];
  int          n_coef;
  int          n_grp;
  int          gap_sum;

  // Expected beats, in input order
  alpha_t exp_alpha_q [$];
  logic   exp_last_q  [$];
  int     exp_grp_q   [$];
  alpha_t e_alpha;
  logic   e_last;
  int     e_grp;

  int   out_cnt;
  int   grp_err;
  int   idle_err;
  int   file_err;
  int   extra_beats;
  int   pass_cnt;
  int   fail_cnt;
  logic idle_chk;
  logic limit_ready;
  int   limit_cycles;

  softmax_top i_dut (
    .clk           (clk),
    .rst_n         (rst_n),
    .cfg_wr        (cfg_wr),
    .cfg_addr      (cfg_addr),
    .cfg_num_nodes (cfg_num_nodes),
    .coef_vld      (coef_vld),
    .coef          (coef),
    .alpha_vld     (alpha_vld),
    .alpha         (alpha),
    .alpha_last    (alpha_last)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic record_result(input string name, input int errs);
    if (errs == 0) begin
      pass_cnt++;
      $display("%s: PASS", name);
    end else begin
      fail_cnt++;
      $display("%s: FAIL (%0d errors)", name, errs);
    end
  endtask

  // ====================
  // Pattern file and its cross-check
  // ====================
  task automatic read_patterns();
    int     k;
    int     base;
    int     sg;
    int     nd;
    logic   dl;
    longint rv;
    $readmemh("testbench/softmax_patterns.txt", pat_mem);
    for (k = 0; k < NUM_SG; k++) begin
      counts[k] = int'(pat_mem[k]);
      assert (counts[k] >= 1 && counts[k] <= 16) else begin
        $display("Pattern file gives table entry %0d an invalid node count", k);
        file_err++;
      end
    end
    n_coef = 0;
    while (n_coef < MAX_COEF && pat_mem[NUM_SG + 4 * n_coef] != 16'h00ff) begin
      n_coef++;
    end
    sg = 0;
    nd = 0;
    n_grp = 0;
    gap_sum = 0;
    for (k = 0; k < n_coef; k++) begin
      base       = NUM_SG + 4 * k;
      coef_a[k]  = coef_t'(pat_mem[base]);
      alpha_a[k] = pat_mem[base + 1];
      last_a[k]  = pat_mem[base + 2][0];
      gap_a[k]   = int'(pat_mem[base + 3]);
      gap_sum   += gap_a[k];
      if (nd == 0) begin
        grp_sum[n_grp] = 0;
      end
      grp_a[k] = n_grp;
      grp_sum[n_grp] += longint'(1) << coef_a[k];
      // Subgraph boundaries follow the count table
      dl = (nd + 1 == counts[sg]);
      assert (last_a[k] == dl) else begin
        $display("Pattern line %0d has last flag %0b, the count table implies %0b",
                 k, last_a[k], dl);
        file_err++;
      end
      if (dl) begin
        grp_sg[n_grp] = sg;
        grp_n[n_grp]  = counts[sg];
        n_grp++;
        nd = 0;
        sg = (sg + 1) % NUM_SG;
      end else begin
        nd++;
      end
    end
    assert (n_coef > 0 && nd == 0) else begin
      $display("Pattern file has no coefficients or stops inside a subgraph");
      file_err++;
    end
    // floor(2^(coef+15) / sum)
    for (k = 0; k < n_coef; k++) begin
      rv = (longint'(1) << (int'(coef_a[k]) + 15)) / grp_sum[grp_a[k]];
      assert (alpha_a[k] == alpha_t'(rv)) else begin
        $display("Pattern line %0d expects 0x%04h, the floor rule gives 0x%04h",
                 k, alpha_a[k], rv);
        file_err++;
      end
    end
  endtask

  // ====================
  // Stimulus
  // ====================
  task automatic load_count_table();
    int k;
    for (k = 0; k < NUM_SG; k++) begin
      @(posedge clk);
      cfg_wr        <= 1'b1;
      cfg_addr      <= subgraph_addr_t'(k);
      cfg_num_nodes <= node_cnt_t'(counts[k]);
    end
    @(posedge clk);
    cfg_wr <= 1'b0;
  endtask

  task automatic stream_coefficients();
    int k;
    for (k = 0; k < n_coef; k++) begin
      @(posedge clk);
      coef_vld <= 1'b1;
      coef     <= coef_a[k];
      exp_alpha_q.push_back(alpha_a[k]);
      exp_last_q.push_back(last_a[k]);
      exp_grp_q.push_back(grp_a[k]);
      repeat (gap_a[k]) begin
        @(posedge clk);
        coef_vld <= 1'b0;
      end
    end
    @(posedge clk);
    coef_vld <= 1'b0;
  endtask

  // Output monitor, sampled away from the active edge
  always @(negedge clk) begin
    if (idle_chk) begin
      assert (!alpha_vld) else begin
        $display("Error at %0t ns: alpha_vld expected 0, got %0b", $time, alpha_vld);
        idle_err++;
      end
    end else if (rst_n && alpha_vld) begin
      assert (exp_alpha_q.size() > 0) else begin
        $display("Output beat at %0t ns has no coefficient left to match", $time);
        extra_beats++;
      end
      if (exp_alpha_q.size() > 0) begin
        e_alpha = exp_alpha_q.pop_front();
        e_last  = exp_last_q.pop_front();
        e_grp   = exp_grp_q.pop_front();
        assert (alpha === e_alpha) else begin
          $display("Error at %0t ns: alpha expected 0x%04h, got 0x%04h", $time, e_alpha, alpha);
          grp_err++;
        end
        assert (alpha_last === e_last) else begin
          $display("Error at %0t ns: alpha_last expected %0b, got %0b",
                   $time, e_last, alpha_last);
          grp_err++;
        end
        out_cnt++;
        if (e_last) begin
          record_result($sformatf("Subgraph %0d (table entry %0d, %0d nodes)",
                                  e_grp, grp_sg[e_grp], grp_n[e_grp]), grp_err);
          grp_err = 0;
        end
      end
    end
  end

  // ====================
  // Main sequence
  // ====================
  initial begin
    rst_n         = 1'b0;
    cfg_wr        = 1'b0;
    cfg_addr      = '0;
    cfg_num_nodes = '0;
    coef_vld      = 1'b0;
    coef          = '0;
    out_cnt       = 0;
    grp_err       = 0;
    idle_err      = 0;
    file_err      = 0;
    extra_beats   = 0;
    pass_cnt      = 0;
    fail_cnt      = 0;
    idle_chk      = 1'b1;
    limit_ready   = 1'b0;
    read_patterns();
    record_result("Pattern file check", file_err);
    limit_cycles = n_coef * (`SM_DIV_LATENCY + 4) + gap_sum + 200;
    limit_ready  = 1'b1;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    load_count_table();
    repeat (10) @(posedge clk);
    idle_chk = 1'b0;
    record_result("No output before streaming", idle_err);
    stream_coefficients();
    wait (out_cnt >= n_coef);
    // Room for any stray beat to show up
    repeat (`SM_DIV_LATENCY + 4) @(posedge clk);
    record_result("One weight per coefficient", extra_beats);
    $display("Tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    wait (limit_ready);
    repeat (limit_cycles) @(posedge clk);
    $display("Timeout after %0d cycles, outputs are missing: %0d of %0d weights seen",
             limit_cycles, out_cnt, n_coef);
    $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== softmax_unit.f ====
+incdir+include
logic/softmax_pkg.sv
logic/sync_fifo.sv
logic/node_count_ram.sv
logic/fxp_div_pipe.sv
logic/softmax.sv
logic/softmax_top.sv
testbench/tb_softmax_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the softmax testbench with Verilator, runs it, and checks the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module tb_softmax_top \
  -f softmax_unit.f -o tb_softmax_top > build.log 2>&1 \
  && ./obj_dir/tb_softmax_top > sim.log 2>&1 \
  || { echo "Build or simulation error, see build.log and sim.log"; exit 1; }
cat sim.log
grep -q "Simulation failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "Simulation completed successfully" sim.log \
  && echo "PASS" \
  || { echo "FAIL: no result line in sim.log"; exit 1; }

// ==== testbench/softmax_patterns.txt ====
// Node counts of table entries 0 to 7, then one line per coefficient (all hex)
// Columns: coef, expected alpha, last flag, idle cycles after it; coef ff ends the stream
01 03 10 02 01 01 02 03
5 8000 1 3
f 7f7f 0 0
0 0000 0 2
7 007f 1 0
f 0800 0 0
f 0800 0 0
f 0800 0 0
f 0800 0 0
f 0800 0 0
f 0800 0 0
f 0800 0 0
f 0800 0 0
f 0800 0 0
f 0800 0 0
f 0800 0 0
f 0800 0 0
f 0800 0 0
f 0800 0 0
f 0800 0 0
f 0800 1 0
1 2aaa 0 0
2 5555 1 0
f 8000 1 0
0 8000 1 1
4 4000 0 1
4 4000 1 0
a 1249 0 0
c 4924 0 3
b 2492 1 2
8 8000 1 0
ff 0 0 0
